//--- ts_pkg.sv
`default_nettype none

////////////////////
// Transport stream
////////////////////

package ts_pkg;

	// One transport-stream byte as it arrives on the input
	typedef logic [7:0] ts_byte_t;

	// Sync byte at the head of every 188-byte packet
	localparam ts_byte_t TS_SYNC_BYTE = 8'h47;

endpackage

`default_nettype wire

//--- asi_pkg.sv
`default_nettype none

////////////////////
// ASI line coding
////////////////////

package asi_pkg;

	// Bits per transmission character
	localparam int SYM_BITS = 10;

	// 10-bit code, bit 0 is "a" and leaves first
	typedef logic [SYM_BITS-1:0] code_t;

	// Unencoded character with K flag above the byte
	typedef struct packed {
		logic       k;
		logic [7:0] data;
	} char_t;

	// Bit position inside a symbol, 0 to 9
	typedef logic [3:0] phase_t;

	// Running disparity of the line
	typedef enum logic {
		RD_NEG = 1'b0,
		RD_POS = 1'b1
	} disp_t;

	// Comma character and its two line forms
	localparam logic [7:0] K28_5     = 8'hBC;
	localparam code_t      K28_5_RDN = 10'b0101111100;
	localparam code_t      K28_5_RDP = 10'b1010000011;

endpackage

`default_nettype wire

//--- ts_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ts_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic             din_clk,
	input  logic             rst,
	input  logic             wr,
	input  logic             rd,
	input  ts_pkg::ts_byte_t wdata,
	output ts_pkg::ts_byte_t rdata,
	output logic             empty,
	output logic             full,
	output logic             overflow
);

	// Address width, depth is a power of two
	localparam int AW = $clog2(FIFO_DEPTH);

	// Byte storage
	ts_pkg::ts_byte_t mem [FIFO_DEPTH];

	// Pointers with one wrap bit above the address
	logic [AW:0] wptr;
	logic [AW:0] rptr;
	logic [AW:0] count;
	logic        wr_ok;
	logic        rd_ok;

	// Accepted operations, nothing moves in reset
	assign wr_ok = rst && wr && !full;
	assign rd_ok = rst && rd && !empty;

	// Same address with different wrap bits means full
	assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
	assign empty = (wptr == rptr);

	// Occupancy
	assign count = wptr - rptr;

	////////////////////
	// Pointers and flags
	////////////////////

	always_ff @(posedge din_clk) begin
		if (!rst) begin
			wptr     <= '0;
			rptr     <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_ok) begin
				wptr <= wptr + 1'b1;
			end
			if (rd_ok) begin
				rptr <= rptr + 1'b1;
			end
			// Write into a full buffer is lost, flag holds until reset
			if (wr && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// Memory write and registered read
	always_ff @(posedge din_clk) begin
		if (wr_ok) begin
			mem[wptr[AW-1:0]] <= wdata;
		end
		if (rd_ok) begin
			rdata <= mem[rptr[AW-1:0]];
		end
	end

	// Scheduler pops only when a byte is waiting
	assert property (@(posedge din_clk) disable iff (!rst) rd |-> !empty)
		else $error("ts_fifo: read while empty");

	// Pointer distance never passes the depth
	assert property (@(posedge din_clk) disable iff (!rst) count <= FIFO_DEPTH)
		else $error("ts_fifo: occupancy above depth");

endmodule

`default_nettype wire

//--- asi_symbol_sched.sv
`timescale 1ns/1ps
`default_nettype none

module asi_symbol_sched (
	input  logic             din_clk,
	input  logic             rst,
	input  logic             empty,
	input  ts_pkg::ts_byte_t rdata,
	output logic             rd,
	output logic             char_load,
	output logic             sync_char,
	output asi_pkg::char_t   char
);

	// Phases of interest within a symbol
	localparam asi_pkg::phase_t PH_POP  = 4'd7;
	localparam asi_pkg::phase_t PH_CHAR = 4'd8;
	localparam asi_pkg::phase_t PH_LAST = asi_pkg::phase_t'(asi_pkg::SYM_BITS - 1);

	asi_pkg::phase_t phase;
	logic            popped;

	////////////////////
	// Symbol phase
	////////////////////

	// Held at the last phase in reset so counting opens at 0
	always_ff @(posedge din_clk) begin
		if (!rst) begin
			phase <= PH_LAST;
		end else if (phase == PH_LAST) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Pop request, the only place empty is looked at
	assign rd = (phase == PH_POP) && !empty;

	// Pop memory and character strobe, one cycle after phase 7
	always_ff @(posedge din_clk) begin
		if (!rst) begin
			popped    <= 1'b0;
			char_load <= 1'b0;
		end else begin
			popped    <= rd;
			char_load <= (phase == PH_POP);
		end
	end

	////////////////////
	// Character choice
	////////////////////

	// FIFO byte if one was popped, comma otherwise
	always_comb begin
		if (popped) begin
			char.k    = 1'b0;
			char.data = rdata;
		end else begin
			char.k    = 1'b1;
			char.data = asi_pkg::K28_5;
		end
	end

	// Packet start marker travels with the character
	assign sync_char = char_load && popped && (rdata == ts_pkg::TS_SYNC_BYTE);

	// Strobe sits on phase 8 and repeats once per symbol
	assert property (@(posedge din_clk) disable iff (!rst)
		char_load |-> (phase == PH_CHAR) ##(asi_pkg::SYM_BITS) char_load)
		else $error("asi_symbol_sched: char_load off phase");

endmodule

`default_nettype wire

//--- enc_8b10b.sv
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b (
	input  logic           din_clk,
	input  logic           rst,
	input  logic           char_load,
	input  logic           sync_char,
	input  asi_pkg::char_t char,
	output asi_pkg::code_t code,
	output logic           code_load,
	output logic           code_sync
);

	////////////////////
	// Code tables
	////////////////////

	// 5b/6b for RD-, written abcdei with a on the left
	function automatic logic [5:0] enc6(input logic [4:0] x);
		case (x)
			5'd0:    enc6 = 6'b100111;
			5'd1:    enc6 = 6'b011101;
			5'd2:    enc6 = 6'b101101;
			5'd3:    enc6 = 6'b110001;
			5'd4:    enc6 = 6'b110101;
			5'd5:    enc6 = 6'b101001;
			5'd6:    enc6 = 6'b011001;
			5'd7:    enc6 = 6'b111000;
			5'd8:    enc6 = 6'b111001;
			5'd9:    enc6 = 6'b100101;
			5'd10:   enc6 = 6'b010101;
			5'd11:   enc6 = 6'b110100;
			5'd12:   enc6 = 6'b001101;
			5'd13:   enc6 = 6'b101100;
			5'd14:   enc6 = 6'b011100;
			5'd15:   enc6 = 6'b010111;
			5'd16:   enc6 = 6'b011011;
			5'd17:   enc6 = 6'b100011;
			5'd18:   enc6 = 6'b010011;
			5'd19:   enc6 = 6'b110010;
			5'd20:   enc6 = 6'b001011;
			5'd21:   enc6 = 6'b101010;
			5'd22:   enc6 = 6'b011010;
			5'd23:   enc6 = 6'b111010;
			5'd24:   enc6 = 6'b110011;
			5'd25:   enc6 = 6'b100110;
			5'd26:   enc6 = 6'b010110;
			5'd27:   enc6 = 6'b110110;
			5'd28:   enc6 = 6'b001110;
			5'd29:   enc6 = 6'b101110;
			5'd30:   enc6 = 6'b011110;
			default: enc6 = 6'b101011;
		endcase
	endfunction

	// 3b/4b for RD-, written fghj, A7 replaces P7 where runs would exceed five
	function automatic logic [3:0] enc4(input logic [2:0] y, input logic alt);
		case (y)
			3'd0:    enc4 = 4'b1011;
			3'd1:    enc4 = 4'b1001;
			3'd2:    enc4 = 4'b0101;
			3'd3:    enc4 = 4'b1100;
			3'd4:    enc4 = 4'b1101;
			3'd5:    enc4 = 4'b1010;
			3'd6:    enc4 = 4'b0110;
			default: enc4 = alt ? 4'b0111 : 4'b1110;
		endcase
	endfunction

	asi_pkg::disp_t disp;
	asi_pkg::disp_t disp_next;
	asi_pkg::code_t code_next;
	logic [5:0]     s6_n;
	logic [5:0]     s6;
	logic [3:0]     s4_n;
	logic [3:0]     s4;
	logic           mid_pos;
	logic           alt;
	logic [3:0]     ones;

	////////////////////
	// Encode
	////////////////////

	always_comb begin
		// Six-bit block, complemented under RD+ when unbalanced or D.07
		s6_n = enc6(char.data[4:0]);
		if ((disp == asi_pkg::RD_POS) &&
			(($countones(s6_n) != 3) || (char.data[4:0] == 5'd7))) begin
			s6 = ~s6_n;
		end else begin
			s6 = s6_n;
		end
		// Disparity between the two sub-blocks
		if ($countones(s6) > 3) begin
			mid_pos = 1'b1;
		end else if ($countones(s6) < 3) begin
			mid_pos = 1'b0;
		end else begin
			mid_pos = (disp == asi_pkg::RD_POS);
		end
		// Alternate D.x.7
		if (mid_pos) begin
			alt = char.data[4:0] inside {5'd11, 5'd13, 5'd14};
		end else begin
			alt = char.data[4:0] inside {5'd17, 5'd18, 5'd20};
		end
		s4_n = enc4(char.data[7:5], alt);
		s4   = (mid_pos && (char.data[7:5] inside {3'd0, 3'd3, 3'd4, 3'd7})) ? ~s4_n : s4_n;
		// Bit a lands in bit 0
		for (int i = 0; i < 6; i++) begin
			code_next[i] = s6[5 - i];
		end
		for (int i = 0; i < 4; i++) begin
			code_next[6 + i] = s4[3 - i];
		end
		// Comma overrides the data path
		if (char.k) begin
			code_next = (disp == asi_pkg::RD_NEG) ? asi_pkg::K28_5_RDN : asi_pkg::K28_5_RDP;
		end
	end

	// Disparity after the whole code
	assign ones = 4'($countones(code_next));

	always_comb begin
		if (ones > 4'd5) begin
			disp_next = asi_pkg::RD_POS;
		end else if (ones < 4'd5) begin
			disp_next = asi_pkg::RD_NEG;
		end else begin
			disp_next = disp;
		end
	end

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge din_clk) begin
		if (!rst) begin
			disp      <= asi_pkg::RD_NEG;
			code_load <= 1'b0;
			code_sync <= 1'b0;
		end else begin
			code_load <= char_load;
			if (char_load) begin
				disp      <= disp_next;
				code_sync <= sync_char;
			end
		end
	end

	always_ff @(posedge din_clk) begin
		if (char_load) begin
			code <= code_next;
		end
	end

	// Every code leaving the encoder stays within one of balance
	assert property (@(posedge din_clk) disable iff (!rst)
		code_load |-> ($countones(code) inside {4, 5, 6}))
		else $error("enc_8b10b: code out of balance");

endmodule

`default_nettype wire

//--- asi_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module asi_serializer (
	input  logic           din_clk,
	input  logic           rst,
	input  logic           code_load,
	input  logic           code_sync,
	input  asi_pkg::code_t code,
	output logic           asi_out,
	output logic           sym_start,
	output logic           ts_start
);

	asi_pkg::code_t shreg;

	////////////////////
	// Shift register
	////////////////////

	// Load on code_load, then one bit per clock toward bit 0
	always_ff @(posedge din_clk) begin
		if (!rst) begin
			shreg     <= '0;
			sym_start <= 1'b0;
			ts_start  <= 1'b0;
		end else begin
			// Phase 0 markers
			sym_start <= code_load;
			ts_start  <= code_load && code_sync;
			if (code_load) begin
				shreg <= code;
			end else begin
				shreg <= {1'b0, shreg[asi_pkg::SYM_BITS-1:1]};
			end
		end
	end

	// Bit a goes out first
	assign asi_out = shreg[0];

	// Upstream pipeline keeps exactly one code per symbol
	assert property (@(posedge din_clk) disable iff (!rst)
		code_load |=> (!code_load) [*(asi_pkg::SYM_BITS - 1)] ##1 code_load)
		else $error("asi_serializer: code_load spacing broken");

endmodule

`default_nettype wire

//--- ts2asi.sv
`timescale 1ns/1ps
`default_nettype none

module ts2asi #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic             din_clk,
	input  logic             rst,
	input  logic             valid,
	input  ts_pkg::ts_byte_t din_8b,
	output logic             asi_out,
	output logic             sym_start,
	output logic             ts_start,
	output logic             full,
	output logic             overflow
);

	// FIFO to scheduler
	logic             empty;
	logic             rd;
	ts_pkg::ts_byte_t rdata;

	// Scheduler to encoder
	logic             char_load;
	logic             sync_char;
	asi_pkg::char_t   char;

	// Encoder to serializer
	asi_pkg::code_t   code;
	logic             code_load;
	logic             code_sync;

	////////////////////
	// Input buffer
	////////////////////

	ts_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.din_clk  (din_clk),
		.rst      (rst),
		.wr       (valid),
		.rd       (rd),
		.wdata    (din_8b),
		.rdata    (rdata),
		.empty    (empty),
		.full     (full),
		.overflow (overflow)
	);

	// Data or comma once per symbol
	asi_symbol_sched u_sched (
		.din_clk   (din_clk),
		.rst       (rst),
		.empty     (empty),
		.rdata     (rdata),
		.rd        (rd),
		.char_load (char_load),
		.sync_char (sync_char),
		.char      (char)
	);

	////////////////////
	// Line coding
	////////////////////

	enc_8b10b u_enc (
		.din_clk   (din_clk),
		.rst       (rst),
		.char_load (char_load),
		.sync_char (sync_char),
		.char      (char),
		.code      (code),
		.code_load (code_load),
		.code_sync (code_sync)
	);

	asi_serializer u_ser (
		.din_clk   (din_clk),
		.rst       (rst),
		.code_load (code_load),
		.code_sync (code_sync),
		.code      (code),
		.asi_out   (asi_out),
		.sym_start (sym_start),
		.ts_start  (ts_start)
	);

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 100
) (
	output logic din_clk
);

	// Free-running clock, first rising edge at half a period
	initial begin
		din_clk = 1'b0;
		forever begin
			#(PERIOD / 2) din_clk = ~din_clk;
		end
	end

endmodule

`default_nettype wire

//--- tb_ts2asi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ts2asi;

	localparam int CLK_PERIOD = 100;
	localparam int FIFO_DEPTH = 16;
	// Commas that must follow once the FIFO has drained
	localparam int TAIL_SYMS  = 5;

	// DUT ports
	logic             din_clk;
	logic             rst;
	logic             valid;
	ts_pkg::ts_byte_t din_8b;
	logic             asi_out;
	logic             sym_start;
	logic             ts_start;
	logic             full;
	logic             overflow;

	// File lines with one driven cycle each plus idle cycles
	bit               ln_valid [$];
	ts_pkg::ts_byte_t ln_byte  [$];
	int               ln_gap   [$];

	// Written bytes in order with both line forms and a burst marker
	ts_pkg::ts_byte_t tx_byte  [$];
	asi_pkg::code_t   tx_rdn   [$];
	asi_pkg::code_t   tx_rdp   [$];
	bit               tx_burst [$];
	int               burst_first;

	// Receive side state
	ts_pkg::ts_byte_t rx_bytes [$];
	asi_pkg::disp_t   tb_disp;
	asi_pkg::code_t   rx_code;
	int               bit_idx;
	logic             start_flag;
	int               next_tx;
	int               sym_count;
	int               comma_count;
	int               target;
	bit               loaded;
	bit               drain_done;
	bit               seen_full;
	bit               seen_ovf;

	tb_clkgen #(
		.PERIOD (CLK_PERIOD)
	) u_clkgen (
		.din_clk (din_clk)
	);

	ts2asi #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (
		.din_clk   (din_clk),
		.rst       (rst),
		.valid     (valid),
		.din_8b    (din_8b),
		.asi_out   (asi_out),
		.sym_start (sym_start),
		.ts_start  (ts_start),
		.full      (full),
		.overflow  (overflow)
	);

	////////////////////
	// Failure reporting
	////////////////////

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_code(input string name, input asi_pkg::code_t got,
		input asi_pkg::code_t exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input ts_pkg::ts_byte_t got,
		input ts_pkg::ts_byte_t exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	////////////////////
	// Stimulus file
	////////////////////

	// File writes codes bit a first while code_t keeps bit a in bit 0
	function automatic asi_pkg::code_t reverse_code(input logic [asi_pkg::SYM_BITS-1:0] v);
		asi_pkg::code_t r;
		for (int i = 0; i < asi_pkg::SYM_BITS; i++) begin
			r[i] = v[asi_pkg::SYM_BITS - 1 - i];
		end
		return r;
	endfunction

	task automatic load_stimulus();
		int         fd;
		int         n;
		int         v;
		int         gap;
		logic [7:0] b;
		logic [9:0] c_n;
		logic [9:0] c_p;
		string      line;
		fd = $fopen("ts2asi_input.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open ts2asi_input.txt");
		end else begin
			burst_first = -1;
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Comment and blank lines do not scan
				if (n > 0) begin
					n = $sscanf(line, "%d %h %b %b %d", v, b, c_n, c_p, gap);
					if (n == 5) begin
						ln_valid.push_back(v != 0);
						ln_byte.push_back(b);
						ln_gap.push_back(gap);
						if (v != 0) begin
							// No idle cycles after a byte puts it in the burst
							if ((gap == 0) && (burst_first < 0)) begin
								burst_first = tx_byte.size();
							end
							tx_byte.push_back(b);
							tx_rdn.push_back(reverse_code(c_n));
							tx_rdp.push_back(reverse_code(c_p));
							tx_burst.push_back(gap == 0);
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Inputs change on the falling edge only
	task automatic drive_stimulus();
		for (int i = 0; i < ln_valid.size(); i++) begin
			// Nothing lost before the burst
			if (ln_gap[i] != 0) begin
				check_flag("overflow", overflow, 1'b0);
			end
			valid  = ln_valid[i];
			din_8b = ln_byte[i];
			@(negedge din_clk);
			valid = 1'b0;
			repeat (ln_gap[i]) @(negedge din_clk);
		end
	endtask

	////////////////////
	// Symbol checking
	////////////////////

	// One rebuilt code against the comma or the next written byte
	task automatic handle_symbol(input asi_pkg::code_t code, input logic ts_seen);
		asi_pkg::code_t comma;
		asi_pkg::code_t exp;
		int             j;
		int             hit;
		int             ones;
		comma = (tb_disp == asi_pkg::RD_NEG) ? asi_pkg::K28_5_RDN : asi_pkg::K28_5_RDP;
		hit   = -1;
		if ((code == asi_pkg::K28_5_RDN) || (code == asi_pkg::K28_5_RDP)) begin
			// Idle fill in the right form for the disparity
			check_code("comma symbol", code, comma);
			check_flag("ts_start", ts_seen, 1'b0);
			comma_count++;
		end else begin
			j = next_tx;
			// Only burst bytes may have been dropped
			while ((hit < 0) && !drain_done && (j < tx_byte.size())) begin
				exp = (tb_disp == asi_pkg::RD_NEG) ? tx_rdn[j] : tx_rdp[j];
				if (code == exp) begin
					hit = j;
				end else if (!tx_burst[j]) begin
					j = tx_byte.size();
				end else begin
					j++;
				end
			end
			if (hit < 0) begin
				if (!drain_done && (next_tx < tx_byte.size())) begin
					exp = (tb_disp == asi_pkg::RD_NEG) ? tx_rdn[next_tx] : tx_rdp[next_tx];
				end else begin
					exp = comma;
				end
				check_code("asi_out symbol", code, exp);
			end else begin
				next_tx = hit + 1;
				rx_bytes.push_back(tx_byte[hit]);
				// Packet start marker only on the sync byte
				check_flag("ts_start", ts_seen, tx_byte[hit] == ts_pkg::TS_SYNC_BYTE);
			end
		end
		// Disparity flips on any code that is not balanced
		ones = $countones(code);
		if (ones > 5) begin
			tb_disp = asi_pkg::RD_POS;
		end else if (ones < 5) begin
			tb_disp = asi_pkg::RD_NEG;
		end
		sym_count++;
	endtask

	// Collector samples DUT outputs on the falling edge
	always @(negedge din_clk) begin
		if (rst) begin
			if (ts_start && !sym_start) begin
				report_failure("ts_start high outside a symbol start");
			end
			if (sym_start) begin
				if ((bit_idx >= 0) && (bit_idx < asi_pkg::SYM_BITS)) begin
					report_failure("sym_start came before the previous symbol ended");
				end
				bit_idx    = 0;
				start_flag = ts_start;
			end else if (bit_idx == asi_pkg::SYM_BITS) begin
				report_failure("sym_start missing after a full symbol");
			end else if (bit_idx < 0) begin
				// Line idles low before the first symbol
				check_flag("asi_out", asi_out, 1'b0);
			end
			if ((bit_idx >= 0) && (bit_idx < asi_pkg::SYM_BITS)) begin
				rx_code[bit_idx] = asi_out;
				bit_idx++;
				if (bit_idx == asi_pkg::SYM_BITS) begin
					handle_symbol(rx_code, start_flag);
				end
			end
			if (full) begin
				seen_full = 1'b1;
			end
			// Sticky loss flag
			if (overflow) begin
				seen_ovf = 1'b1;
			end else if (seen_ovf) begin
				check_flag("overflow", overflow, 1'b1);
			end
		end
	end

	////////////////////
	// Watchdog
	////////////////////

	// Every file line plus 40 spare symbols
	initial begin
		wait (loaded);
		#((ln_valid.size() + 40) * asi_pkg::SYM_BITS * CLK_PERIOD);
		report_failure("watchdog expired before the test finished");
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst         = 1'b0;
		valid       = 1'b0;
		din_8b      = '0;
		tb_disp     = asi_pkg::RD_NEG;
		bit_idx     = -1;
		start_flag  = 1'b0;
		next_tx     = 0;
		sym_count   = 0;
		comma_count = 0;
		loaded      = 1'b0;
		drain_done  = 1'b0;
		seen_full   = 1'b0;
		seen_ovf    = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		// Reset over five rising edges
		repeat (5) @(posedge din_clk);
		@(negedge din_clk);
		rst = 1'b1;
		// First symbol start on the 11th edge with rst high
		for (int k = 1; k <= 11; k++) begin
			@(negedge din_clk);
			if (k == 1) begin
				check_flag("ts_start", ts_start, 1'b0);
				check_flag("full", full, 1'b0);
				check_flag("overflow", overflow, 1'b0);
			end
			check_flag("sym_start", sym_start, k == 11);
		end
		drive_stimulus();
		// FIFO has drained at the first comma after the input ends
		target = comma_count + 1;
		wait (comma_count >= target);
		// From here on only commas
		drain_done = 1'b1;
		target = sym_count + TAIL_SYMS;
		wait (sym_count >= target);
		check_flag("full seen", seen_full, 1'b1);
		check_flag("overflow", overflow, 1'b1);
		if ((burst_first < 0) || (rx_bytes.size() < burst_first + FIFO_DEPTH)) begin
			report_failure($sformatf("only %0d bytes received, burst head incomplete",
				rx_bytes.size()));
		end else begin
			// Paced bytes and the head of the burst with none skipped
			for (int i = 0; i < burst_first + FIFO_DEPTH; i++) begin
				check_byte("received byte", rx_bytes[i], tx_byte[i]);
			end
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- ts2asi_input.txt
# valid byte(hex) code_rd_minus code_rd_plus idle_cycles
# codes in line order with bit a first; idle_cycles 0 marks the back-to-back burst
0 00 0000000000 0000000000 3
1 47 1110000101 0001110101 9
1 00 1001110100 0110001011 9
1 03 1100011011 1100010100 9
1 11 1000111011 1000110100 9
1 F1 1000110111 1000110001 9
1 EB 1101001110 1101001000 9
1 07 1110001011 0001110100 9
1 60 1001110011 0110001100 9
1 BC 0011101010 0011101010 9
1 FF 1010110001 0101001110 9
1 1F 1010110100 0101001011 9
1 A5 1010011010 1010011010 9
1 3C 0011101001 0011101001 9
1 55 1010100101 1010100101 9
1 47 1110000101 0001110101 9
1 47 1110000101 0001110101 0
1 00 1001110100 0110001011 0
1 03 1100011011 1100010100 0
1 11 1000111011 1000110100 0
1 F1 1000110111 1000110001 0
1 EB 1101001110 1101001000 0
1 07 1110001011 0001110100 0
1 60 1001110011 0110001100 0
1 BC 0011101010 0011101010 0
1 FF 1010110001 0101001110 0
1 1F 1010110100 0101001011 0
1 A5 1010011010 1010011010 0
1 3C 0011101001 0011101001 0
1 55 1010100101 1010100101 0
1 47 1110000101 0001110101 0
1 00 1001110100 0110001011 0
1 03 1100011011 1100010100 0
1 11 1000111011 1000110100 0
1 F1 1000110111 1000110001 0
1 EB 1101001110 1101001000 0
1 07 1110001011 0001110100 0
1 60 1001110011 0110001100 0
1 BC 0011101010 0011101010 0
1 FF 1010110001 0101001110 0
1 1F 1010110100 0101001011 0
1 A5 1010011010 1010011010 0
1 3C 0011101001 0011101001 0
1 55 1010100101 1010100101 0
1 47 1110000101 0001110101 0
1 00 1001110100 0110001011 0
1 03 1100011011 1100010100 0
1 11 1000111011 1000110100 0
1 F1 1000110111 1000110001 0
1 EB 1101001110 1101001000 0
1 07 1110001011 0001110100 0
1 60 1001110011 0110001100 0
1 BC 0011101010 0011101010 0
1 FF 1010110001 0101001110 0
1 1F 1010110100 0101001011 0
1 A5 1010011010 1010011010 0

//--- ts2asi.f
ts_pkg.sv
asi_pkg.sv
ts_fifo.sv
asi_symbol_sched.sv
enc_8b10b.sv
asi_serializer.sv
ts2asi.sv
tb_clkgen.sv
tb_ts2asi.sv
